// File: logic/cpu_params.svh
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Width of one data word and of every address held in the datapath.
`define REG_BUS_WIDTH 32

// Register file addressing for the 32 integer registers.
`define REG_ADDR_WIDTH 5
`define REG_NUM 32

// Set to 1'b0 to leave the multiplier out of the execute stage.
// Multiply results then read as zero.
`define MUL_ENABLE 1'b1

// Reset and default value of data words.
`define ZERO_WORD {`REG_BUS_WIDTH{1'b0}}

`endif

// File: logic/cpu_pkg.sv
`include "cpu_params.svh"

package cpu_pkg;

  // bit positions in the one-hot ALU operation vector.
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SRL    = 4'd3,
    ALU_SRA    = 4'd4,
    ALU_SLT    = 4'd5,
    ALU_SLTU   = 4'd6,
    ALU_OR     = 4'd7,
    ALU_XOR    = 4'd8,
    ALU_AND    = 4'd9,
    ALU_MUL    = 4'd10,
    ALU_MULH   = 4'd11,
    ALU_MULHSU = 4'd12,
    ALU_MULHU  = 4'd13,
    ALU_LINK   = 4'd14
  } alu_op_e;

  localparam int ALU_OP_NUM = 15;

  typedef enum logic {SRC1_REG = 1'b0, SRC1_PC  = 1'b1} src1_e;
  typedef enum logic {SRC2_REG = 1'b0, SRC2_IMM = 1'b1} src2_e;

  typedef struct packed {
    logic [`REG_BUS_WIDTH-1:0]  pc;
    logic [`REG_BUS_WIDTH-1:0]  rs1;
    logic [`REG_BUS_WIDTH-1:0]  rs2;
    logic [`REG_BUS_WIDTH-1:0]  imm;
    logic [`REG_BUS_WIDTH-1:0]  link_addr;
    logic [ALU_OP_NUM-1:0]      aluop;
    src1_e                      alusrc1;
    src2_e                      alusrc2;
    logic                       we;
    logic [`REG_ADDR_WIDTH-1:0] waddr;
    logic                       illegal;
  } id_ex_t;

  typedef struct packed {
    logic [`REG_BUS_WIDTH-1:0]  result;
    logic [`REG_BUS_WIDTH-1:0]  store_data;
    logic                       we;
    logic [`REG_ADDR_WIDTH-1:0] waddr;
    logic                       illegal;
  } ex_wb_t;

endpackage

// File: logic/isa_pkg.sv
package isa_pkg;

  // major opcodes of the supported RV32 instruction groups.
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  // integer operations, shared by OP and OP-IMM.
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // multiply group under F7_MULDIV.
  localparam logic [2:0] F3_MUL    = 3'b000;
  localparam logic [2:0] F3_MULH   = 3'b001;
  localparam logic [2:0] F3_MULHSU = 3'b010;
  localparam logic [2:0] F3_MULHU  = 3'b011;

  localparam logic [2:0] F3_SB   = 3'b000;
  localparam logic [2:0] F3_SH   = 3'b001;
  localparam logic [2:0] F3_SW   = 3'b010;
  localparam logic [2:0] F3_JALR = 3'b000;

  localparam logic [6:0] F7_BASE   = 7'b0000000;
  localparam logic [6:0] F7_ALT    = 7'b0100000;
  localparam logic [6:0] F7_MULDIV = 7'b0000001;

endpackage

// File: logic/regfile.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module regfile (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic [`REG_ADDR_WIDTH-1:0] rs1_addr_i,
  input  logic [`REG_ADDR_WIDTH-1:0] rs2_addr_i,
  output logic [`REG_BUS_WIDTH-1:0]  rs1_data_o,
  output logic [`REG_BUS_WIDTH-1:0]  rs2_data_o,
  input  logic                       we_i,
  input  logic [`REG_ADDR_WIDTH-1:0] waddr_i,
  input  logic [`REG_BUS_WIDTH-1:0]  wdata_i
);

  logic [`REG_BUS_WIDTH-1:0] regs [1:`REG_NUM-1]; // x0 has no storage.

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 1; i < `REG_NUM; i++) begin
        regs[i] <= `ZERO_WORD;
      end
    end else if (we_i && (waddr_i != '0)) begin
      regs[waddr_i] <= wdata_i;
    end
  end

  // a write in the same cycle is forwarded so a reader two issues later sees it.
  assign rs1_data_o = (rs1_addr_i == '0)                   ? `ZERO_WORD :
                      (we_i && (waddr_i == rs1_addr_i))    ? wdata_i    :
                                                             regs[rs1_addr_i];

  assign rs2_data_o = (rs2_addr_i == '0)                   ? `ZERO_WORD :
                      (we_i && (waddr_i == rs2_addr_i))    ? wdata_i    :
                                                             regs[rs2_addr_i];

endmodule

// File: logic/id.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module id (
  input  logic [`REG_BUS_WIDTH-1:0]      inst_i,
  input  logic [`REG_BUS_WIDTH-1:0]      pc_i,
  output logic [`REG_ADDR_WIDTH-1:0]     rs1_addr_o,
  output logic [`REG_ADDR_WIDTH-1:0]     rs2_addr_o,
  input  logic [`REG_BUS_WIDTH-1:0]      rs1_data_i,
  input  logic [`REG_BUS_WIDTH-1:0]      rs2_data_i,
  output logic [`REG_BUS_WIDTH-1:0]      pc_o,
  output logic [`REG_BUS_WIDTH-1:0]      rs1_o,
  output logic [`REG_BUS_WIDTH-1:0]      rs2_o,
  output logic [`REG_BUS_WIDTH-1:0]      imm_o,
  output logic [`REG_BUS_WIDTH-1:0]      link_addr_o,
  output logic [cpu_pkg::ALU_OP_NUM-1:0] aluop_o,
  output cpu_pkg::src1_e                 alusrc1_o,
  output cpu_pkg::src2_e                 alusrc2_o,
  output logic                           we_o,
  output logic [`REG_ADDR_WIDTH-1:0]     waddr_o,
  output logic                           illegal_o
);

  logic [6:0]                opcode;
  logic [2:0]                funct3;
  logic [6:0]                funct7;
  logic [`REG_BUS_WIDTH-1:0] imm_i_type;
  logic [`REG_BUS_WIDTH-1:0] imm_s_type;
  logic [`REG_BUS_WIDTH-1:0] imm_u_type;
  logic [`REG_BUS_WIDTH-1:0] imm_j_type;
  cpu_pkg::alu_op_e          op;
  logic                      legal;

  assign opcode = inst_i[6:0];
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];

  assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
  assign imm_s_type = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_u_type = {inst_i[31:12], 12'b0};
  assign imm_j_type = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  // LUI reads x0 so that it becomes a plain add of the immediate.
  assign rs1_addr_o = (opcode == isa_pkg::OPC_LUI) ? '0 : inst_i[19:15];
  assign rs2_addr_o = inst_i[24:20];

  always_comb begin
    op        = cpu_pkg::ALU_ADD;
    alusrc1_o = cpu_pkg::SRC1_REG;
    alusrc2_o = cpu_pkg::SRC2_IMM;
    imm_o     = imm_i_type;
    legal     = 1'b1;
    we_o      = 1'b1;

    unique case (opcode)
      isa_pkg::OPC_OP_IMM: begin
        unique case (funct3)
          isa_pkg::F3_ADD_SUB: op = cpu_pkg::ALU_ADD;
          isa_pkg::F3_SLT:     op = cpu_pkg::ALU_SLT;
          isa_pkg::F3_SLTU:    op = cpu_pkg::ALU_SLTU;
          isa_pkg::F3_XOR:     op = cpu_pkg::ALU_XOR;
          isa_pkg::F3_OR:      op = cpu_pkg::ALU_OR;
          isa_pkg::F3_AND:     op = cpu_pkg::ALU_AND;
          isa_pkg::F3_SLL: begin
            op    = cpu_pkg::ALU_SLL;
            legal = (funct7 == isa_pkg::F7_BASE);
          end
          default: begin // funct7 picks the fill of a right shift.
            op    = (funct7 == isa_pkg::F7_ALT) ? cpu_pkg::ALU_SRA : cpu_pkg::ALU_SRL;
            legal = (funct7 == isa_pkg::F7_ALT) || (funct7 == isa_pkg::F7_BASE);
          end
        endcase
      end
      isa_pkg::OPC_OP: begin
        alusrc2_o = cpu_pkg::SRC2_REG;
        unique case ({funct7, funct3})
          {isa_pkg::F7_BASE,   isa_pkg::F3_ADD_SUB}: op = cpu_pkg::ALU_ADD;
          {isa_pkg::F7_ALT,    isa_pkg::F3_ADD_SUB}: op = cpu_pkg::ALU_SUB;
          {isa_pkg::F7_BASE,   isa_pkg::F3_SLL}:     op = cpu_pkg::ALU_SLL;
          {isa_pkg::F7_BASE,   isa_pkg::F3_SLT}:     op = cpu_pkg::ALU_SLT;
          {isa_pkg::F7_BASE,   isa_pkg::F3_SLTU}:    op = cpu_pkg::ALU_SLTU;
          {isa_pkg::F7_BASE,   isa_pkg::F3_XOR}:     op = cpu_pkg::ALU_XOR;
          {isa_pkg::F7_BASE,   isa_pkg::F3_SRL_SRA}: op = cpu_pkg::ALU_SRL;
          {isa_pkg::F7_ALT,    isa_pkg::F3_SRL_SRA}: op = cpu_pkg::ALU_SRA;
          {isa_pkg::F7_BASE,   isa_pkg::F3_OR}:      op = cpu_pkg::ALU_OR;
          {isa_pkg::F7_BASE,   isa_pkg::F3_AND}:     op = cpu_pkg::ALU_AND;
          {isa_pkg::F7_MULDIV, isa_pkg::F3_MUL}:     op = cpu_pkg::ALU_MUL;
          {isa_pkg::F7_MULDIV, isa_pkg::F3_MULH}:    op = cpu_pkg::ALU_MULH;
          {isa_pkg::F7_MULDIV, isa_pkg::F3_MULHSU}:  op = cpu_pkg::ALU_MULHSU;
          {isa_pkg::F7_MULDIV, isa_pkg::F3_MULHU}:   op = cpu_pkg::ALU_MULHU;
          default: legal = 1'b0; // division and unknown funct7.
        endcase
      end
      isa_pkg::OPC_LUI: imm_o = imm_u_type;
      isa_pkg::OPC_AUIPC: begin
        alusrc1_o = cpu_pkg::SRC1_PC;
        imm_o     = imm_u_type;
      end
      isa_pkg::OPC_JAL: begin
        op    = cpu_pkg::ALU_LINK;
        imm_o = imm_j_type;
      end
      isa_pkg::OPC_JALR: begin
        op    = cpu_pkg::ALU_LINK;
        legal = (funct3 == isa_pkg::F3_JALR);
      end
      isa_pkg::OPC_STORE: begin
        imm_o = imm_s_type; // result is the store address.
        we_o  = 1'b0;
        legal = (funct3 == isa_pkg::F3_SB) || (funct3 == isa_pkg::F3_SH) ||
                (funct3 == isa_pkg::F3_SW);
      end
      default: legal = 1'b0;
    endcase

    if (!legal) begin
      op   = cpu_pkg::ALU_ADD;
      we_o = 1'b0;
    end
  end

  always_comb begin
    aluop_o     = '0;
    aluop_o[op] = 1'b1;
  end

  assign illegal_o   = ~legal;
  assign pc_o        = pc_i;
  assign rs1_o       = rs1_data_i;
  assign rs2_o       = rs2_data_i;
  assign link_addr_o = pc_i + `REG_BUS_WIDTH'(4);
  assign waddr_o     = inst_i[11:7];

endmodule

// File: logic/pipe_reg.sv
`timescale 1ns/100ps

module pipe_reg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // payload holds its value between strobes.
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      data_o <= '0;
    end else if (valid_i) begin
      data_o <= data_i;
    end
  end

endmodule

// File: logic/ex.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module ex (
  input  logic [`REG_BUS_WIDTH-1:0]      pc_i,
  input  logic [cpu_pkg::ALU_OP_NUM-1:0] aluop_i,
  input  cpu_pkg::src1_e                 alusrc1_i,
  input  cpu_pkg::src2_e                 alusrc2_i,
  input  logic [`REG_BUS_WIDTH-1:0]      rs1_i,
  input  logic [`REG_BUS_WIDTH-1:0]      rs2_i,
  input  logic [`REG_BUS_WIDTH-1:0]      imm_i,
  input  logic [`REG_BUS_WIDTH-1:0]      link_addr_i,
  output logic [`REG_BUS_WIDTH-1:0]      wdata_o,
  output logic [`REG_BUS_WIDTH-1:0]      wreg_data_o
);

  localparam int MUL_WIDTH = 2 * `REG_BUS_WIDTH;
  localparam int MSB       = `REG_BUS_WIDTH - 1;

  logic [`REG_BUS_WIDTH-1:0] alu_in1;
  logic [`REG_BUS_WIDTH-1:0] alu_in2;
  logic [MUL_WIDTH-1:0]      mulres;

  if (`MUL_ENABLE) begin : g_mul
    logic                      rs1_signed;
    logic                      rs2_signed;
    logic                      neg1;
    logic                      neg2;
    logic [`REG_BUS_WIDTH-1:0] mag1;
    logic [`REG_BUS_WIDTH-1:0] mag2;
    logic [MUL_WIDTH-1:0]      product;

    assign rs1_signed = aluop_i[cpu_pkg::ALU_MUL] | aluop_i[cpu_pkg::ALU_MULH] |
                        aluop_i[cpu_pkg::ALU_MULHSU];
    assign rs2_signed = aluop_i[cpu_pkg::ALU_MUL] | aluop_i[cpu_pkg::ALU_MULH];

    assign neg1 = rs1_signed & rs1_i[MSB];
    assign neg2 = rs2_signed & rs2_i[MSB];

    // multiply magnitudes, then restore the sign of the full product.
    assign mag1    = neg1 ? (~rs1_i + 1'b1) : rs1_i;
    assign mag2    = neg2 ? (~rs2_i + 1'b1) : rs2_i;
    assign product = {{`REG_BUS_WIDTH{1'b0}}, mag1} * {{`REG_BUS_WIDTH{1'b0}}, mag2};
    assign mulres  = (neg1 ^ neg2) ? (~product + 1'b1) : product;
  end else begin : g_no_mul
    assign mulres = '0;
  end

  assign alu_in1 = (alusrc1_i == cpu_pkg::SRC1_REG) ? rs1_i : pc_i;
  assign alu_in2 = (alusrc2_i == cpu_pkg::SRC2_REG) ? rs2_i : imm_i;

  always_comb begin
    unique case (1'b1)
      aluop_i[cpu_pkg::ALU_ADD]:    wreg_data_o = alu_in1 + alu_in2;
      aluop_i[cpu_pkg::ALU_SUB]:    wreg_data_o = alu_in1 - alu_in2;
      aluop_i[cpu_pkg::ALU_SLL]:    wreg_data_o = alu_in1 << alu_in2[4:0];
      aluop_i[cpu_pkg::ALU_SRL]:    wreg_data_o = alu_in1 >> alu_in2[4:0];
      aluop_i[cpu_pkg::ALU_SRA]:    wreg_data_o = $signed(alu_in1) >>> alu_in2[4:0];
      aluop_i[cpu_pkg::ALU_SLT]: begin
        wreg_data_o = ($signed(alu_in1) < $signed(alu_in2)) ? 32'd1 : 32'd0;
      end
      aluop_i[cpu_pkg::ALU_SLTU]: begin
        wreg_data_o = (alu_in1 < alu_in2) ? 32'd1 : 32'd0;
      end
      aluop_i[cpu_pkg::ALU_OR]:     wreg_data_o = alu_in1 | alu_in2;
      aluop_i[cpu_pkg::ALU_XOR]:    wreg_data_o = alu_in1 ^ alu_in2;
      aluop_i[cpu_pkg::ALU_AND]:    wreg_data_o = alu_in1 & alu_in2;
      aluop_i[cpu_pkg::ALU_MUL]:    wreg_data_o = mulres[`REG_BUS_WIDTH-1:0];
      aluop_i[cpu_pkg::ALU_MULH]:   wreg_data_o = mulres[MUL_WIDTH-1:`REG_BUS_WIDTH];
      aluop_i[cpu_pkg::ALU_MULHSU]: wreg_data_o = mulres[MUL_WIDTH-1:`REG_BUS_WIDTH];
      aluop_i[cpu_pkg::ALU_MULHU]:  wreg_data_o = mulres[MUL_WIDTH-1:`REG_BUS_WIDTH];
      aluop_i[cpu_pkg::ALU_LINK]:   wreg_data_o = link_addr_i;
      default:                      wreg_data_o = `ZERO_WORD; // empty bundle after reset.
    endcase
  end

  assign wdata_o = rs2_i;

endmodule

// File: logic/ex_core.sv
`timescale 1ns/100ps
`include "cpu_params.svh"

module ex_core (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       inst_valid_i,
  input  logic [`REG_BUS_WIDTH-1:0]  inst_i,
  input  logic [`REG_BUS_WIDTH-1:0]  pc_i,
  output logic                       wb_valid_o,
  output logic                       wb_we_o,
  output logic [`REG_ADDR_WIDTH-1:0] wb_addr_o,
  output logic [`REG_BUS_WIDTH-1:0]  wb_data_o,
  output logic [`REG_BUS_WIDTH-1:0]  store_data_o,
  output logic                       wb_illegal_o
);

  logic [`REG_ADDR_WIDTH-1:0] rs1_addr;
  logic [`REG_ADDR_WIDTH-1:0] rs2_addr;
  logic [`REG_BUS_WIDTH-1:0]  rs1_data;
  logic [`REG_BUS_WIDTH-1:0]  rs2_data;
  logic                       ex_valid;
  logic                       rf_we;
  cpu_pkg::id_ex_t            id_d;
  cpu_pkg::id_ex_t            id_q;
  cpu_pkg::ex_wb_t            ex_d;
  cpu_pkg::ex_wb_t            wb_q;

  regfile u_regfile (
    .clk_i(clk_i), .rst_i(rst_i),
    .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
    .rs1_data_o(rs1_data), .rs2_data_o(rs2_data),
    .we_i(rf_we), .waddr_i(wb_q.waddr), .wdata_i(wb_q.result)
  );

  id u_id (
    .inst_i(inst_i), .pc_i(pc_i),
    .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr),
    .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .pc_o(id_d.pc), .rs1_o(id_d.rs1), .rs2_o(id_d.rs2), .imm_o(id_d.imm),
    .link_addr_o(id_d.link_addr), .aluop_o(id_d.aluop),
    .alusrc1_o(id_d.alusrc1), .alusrc2_o(id_d.alusrc2),
    .we_o(id_d.we), .waddr_o(id_d.waddr), .illegal_o(id_d.illegal)
  );

  pipe_reg #(.payload_t(cpu_pkg::id_ex_t)) u_id_ex (
    .clk_i(clk_i), .rst_i(rst_i),
    .valid_i(inst_valid_i), .data_i(id_d),
    .valid_o(ex_valid), .data_o(id_q)
  );

  ex u_ex (
    .pc_i(id_q.pc), .aluop_i(id_q.aluop),
    .alusrc1_i(id_q.alusrc1), .alusrc2_i(id_q.alusrc2),
    .rs1_i(id_q.rs1), .rs2_i(id_q.rs2), .imm_i(id_q.imm),
    .link_addr_i(id_q.link_addr),
    .wdata_o(ex_d.store_data), .wreg_data_o(ex_d.result)
  );

  assign ex_d.we      = id_q.we;
  assign ex_d.waddr   = id_q.waddr;
  assign ex_d.illegal = id_q.illegal;

  pipe_reg #(.payload_t(cpu_pkg::ex_wb_t)) u_ex_wb (
    .clk_i(clk_i), .rst_i(rst_i),
    .valid_i(ex_valid), .data_i(ex_d),
    .valid_o(wb_valid_o), .data_o(wb_q)
  );

  assign rf_we        = wb_valid_o & wb_q.we & ~wb_q.illegal; // stale payload never writes.
  assign wb_we_o      = wb_q.we;
  assign wb_addr_o    = wb_q.waddr;
  assign wb_data_o    = wb_q.result;
  assign store_data_o = wb_q.store_data;
  assign wb_illegal_o = wb_q.illegal;

endmodule

// File: verif/tb_ex_core.sv
`timescale 1ns/100ps

module tb_ex_core;

  localparam int CLK_PERIOD     = 40;
  localparam int RESET_CYCLES   = 10;
  localparam int ISSUE_SLOTS    = 160; // issue and idle slots summed over all tests.
  localparam int TIMEOUT_CYCLES = (ISSUE_SLOTS * 3 / 2) * 2 + RESET_CYCLES;

  logic        clk = 1'b0;
  logic        rst;
  logic        inst_valid;
  logic [31:0] inst;
  logic [31:0] inst_pc;
  logic        wb_valid;
  logic        wb_we;
  logic [4:0]  wb_addr;
  logic [31:0] wb_data;
  logic [31:0] store_data;
  logic        wb_illegal;

  logic [31:0] regs_m [32];  // architectural state after every issued instruction.
  logic [70:0] exp_q [$];    // {illegal, we, rd, store data, result}.
  time         due_q [$];
  logic [70:0] got;
  logic [31:0] pc = 32'h0000_1000;
  logic [31:0] lfsr = 32'hdc3a_351d;
  int          errors = 0;
  int          checks = 0;
  int          cycles = 0;

  ex_core u_dut (
    .clk_i(clk), .rst_i(rst), .inst_valid_i(inst_valid), .inst_i(inst), .pc_i(inst_pc),
    .wb_valid_o(wb_valid), .wb_we_o(wb_we), .wb_addr_o(wb_addr), .wb_data_o(wb_data),
    .store_data_o(store_data), .wb_illegal_o(wb_illegal)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // one LFSR step per bit taken.
  function automatic logic [31:0] rand_word(input int nbits);
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < nbits; i++) begin
      w    = {w[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hd000_0001) : (lfsr >> 1);
    end
    return w;
  endfunction

  function automatic logic [31:0] sext12(input logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic logic [31:0] alu_model(input cpu_pkg::alu_op_e op,
                                            input logic [31:0] a, input logic [31:0] b);
    logic [63:0] p_ss;
    logic [63:0] p_su;
    logic [63:0] p_uu;
    p_ss = {{32{a[31]}}, a} * {{32{b[31]}}, b}; // exact modulo 2**64.
    p_su = {{32{a[31]}}, a} * {32'b0, b};
    p_uu = {32'b0, a} * {32'b0, b};
    case (op)
      cpu_pkg::ALU_ADD:    return a + b;
      cpu_pkg::ALU_SUB:    return a - b;
      cpu_pkg::ALU_SLL:    return a << b[4:0];
      cpu_pkg::ALU_SRL:    return a >> b[4:0];
      cpu_pkg::ALU_SRA:    return 32'($signed(a) >>> b[4:0]);
      cpu_pkg::ALU_SLT:    return {31'b0, $signed(a) < $signed(b)};
      cpu_pkg::ALU_SLTU:   return {31'b0, a < b};
      cpu_pkg::ALU_OR:     return a | b;
      cpu_pkg::ALU_XOR:    return a ^ b;
      cpu_pkg::ALU_AND:    return a & b;
      cpu_pkg::ALU_MUL:    return p_ss[31:0];
      cpu_pkg::ALU_MULH:   return p_ss[63:32];
      cpu_pkg::ALU_MULHSU: return p_su[63:32];
      cpu_pkg::ALU_MULHU:  return p_uu[63:32];
      default:             return '0;
    endcase
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, isa_pkg::OPC_OP};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], isa_pkg::OPC_STORE};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, isa_pkg::OPC_JAL};
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      $display("Error at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  // drives one instruction and queues its expected writeback.
  task automatic issue(input logic [31:0] word, input logic we, input logic [4:0] rd,
                       input logic [31:0] result, input logic illegal);
    @(posedge clk);
    inst_valid <= 1'b1;
    inst       <= word;
    inst_pc    <= pc;
    exp_q.push_back({illegal, we, rd, regs_m[word[24:20]], result});
    due_q.push_back($time + 2 * CLK_PERIOD + CLK_PERIOD / 2);
    if (we && !illegal && (rd != 5'd0)) begin
      regs_m[rd] = result;
    end
    pc = pc + 32'd4;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      inst_valid <= 1'b0;
    end
  endtask

  task automatic run_rr(input cpu_pkg::alu_op_e op, input logic [6:0] f7,
                        input logic [2:0] f3, input logic [4:0] rd, rs1, rs2);
    issue(r_type(f7, f3, rd, rs1, rs2), 1'b1, rd, alu_model(op, regs_m[rs1], regs_m[rs2]), 1'b0);
  endtask

  task automatic run_ri(input cpu_pkg::alu_op_e op, input logic [2:0] f3,
                        input logic [11:0] imm, input logic [4:0] rd, input logic [4:0] rs1);
    issue(i_type(imm, rs1, f3, rd, isa_pkg::OPC_OP_IMM), 1'b1, rd,
          alu_model(op, regs_m[rs1], sext12(imm)), 1'b0);
  endtask

  // LUI then ADDI, with the ADDI two slots after the LUI.
  task automatic load(input logic [4:0] rd, input logic [31:0] value);
    logic [19:0] hi;
    hi = value[31:12] + {19'b0, value[11]};
    issue(u_type(hi, rd, isa_pkg::OPC_LUI), 1'b1, rd, {hi, 12'b0}, 1'b0);
    idle(1);
    run_ri(cpu_pkg::ALU_ADD, isa_pkg::F3_ADD_SUB, value[11:0], rd, rd);
    idle(1);
  endtask

  task automatic finish_test(input string name, input int err0);
    idle(1);
    while (exp_q.size() != 0) begin
      @(posedge clk);
    end
    $display("test %-9s done with %0d errors", name, errors - err0);
  endtask

  task automatic test_idle();
    int err0;
    err0 = errors;
    repeat (8) begin
      @(negedge clk);
      checks++;
      if (wb_valid || wb_we || wb_illegal) begin
        $display("Error at %0t ns: wb_valid_o/wb_we_o/wb_illegal_o expected 000, got %b%b%b",
                 $time, wb_valid, wb_we, wb_illegal);
        errors++;
      end
    end
    finish_test("reset", err0);
  endtask

  task automatic test_op_imm();
    int err0;
    err0 = errors;
    load(5'd1, rand_word(32));
    load(5'd2, rand_word(32) | 32'h8000_0000);
    run_ri(cpu_pkg::ALU_ADD, isa_pkg::F3_ADD_SUB, 12'(rand_word(12)), 5'd3, 5'd1);
    run_ri(cpu_pkg::ALU_SLT, isa_pkg::F3_SLT, 12'(rand_word(11)) | 12'h800, 5'd4, 5'd2);
    run_ri(cpu_pkg::ALU_SLTU, isa_pkg::F3_SLTU, 12'hfff, 5'd5, 5'd1);
    run_ri(cpu_pkg::ALU_XOR, isa_pkg::F3_XOR, 12'(rand_word(12)), 5'd6, 5'd1);
    run_ri(cpu_pkg::ALU_OR, isa_pkg::F3_OR, 12'(rand_word(12)), 5'd7, 5'd2);
    run_ri(cpu_pkg::ALU_AND, isa_pkg::F3_AND, 12'(rand_word(12)), 5'd8, 5'd1);
    run_ri(cpu_pkg::ALU_SLL, isa_pkg::F3_SLL, {isa_pkg::F7_BASE, 5'(rand_word(5))}, 5'd9, 5'd1);
    run_ri(cpu_pkg::ALU_SRL, isa_pkg::F3_SRL_SRA, {isa_pkg::F7_BASE, 5'(rand_word(5))},
           5'd10, 5'd2);
    run_ri(cpu_pkg::ALU_SRA, isa_pkg::F3_SRL_SRA, {isa_pkg::F7_ALT, 5'(rand_word(5))},
           5'd11, 5'd2); // sign fill from a negative rs1.
    finish_test("op-imm", err0);
  endtask

  task automatic test_op();
    int err0;
    err0 = errors;
    load(5'd1, rand_word(32));
    load(5'd2, rand_word(32));
    run_rr(cpu_pkg::ALU_ADD, isa_pkg::F7_BASE, isa_pkg::F3_ADD_SUB, 5'd3, 5'd1, 5'd2);
    run_rr(cpu_pkg::ALU_SUB, isa_pkg::F7_ALT, isa_pkg::F3_ADD_SUB, 5'd4, 5'd1, 5'd2);
    run_rr(cpu_pkg::ALU_SLL, isa_pkg::F7_BASE, isa_pkg::F3_SLL, 5'd5, 5'd1, 5'd2);
    run_rr(cpu_pkg::ALU_SRL, isa_pkg::F7_BASE, isa_pkg::F3_SRL_SRA, 5'd6, 5'd1, 5'd2);
    run_rr(cpu_pkg::ALU_SRA, isa_pkg::F7_ALT, isa_pkg::F3_SRL_SRA, 5'd7, 5'd1, 5'd2);
    run_rr(cpu_pkg::ALU_SLT, isa_pkg::F7_BASE, isa_pkg::F3_SLT, 5'd8, 5'd1, 5'd2);
    run_rr(cpu_pkg::ALU_SLTU, isa_pkg::F7_BASE, isa_pkg::F3_SLTU, 5'd9, 5'd1, 5'd2);
    run_rr(cpu_pkg::ALU_XOR, isa_pkg::F7_BASE, isa_pkg::F3_XOR, 5'd10, 5'd1, 5'd2);
    run_rr(cpu_pkg::ALU_OR, isa_pkg::F7_BASE, isa_pkg::F3_OR, 5'd11, 5'd1, 5'd2);
    run_rr(cpu_pkg::ALU_AND, isa_pkg::F7_BASE, isa_pkg::F3_AND, 5'd12, 5'd1, 5'd2);
    // x15 reads x13 two slots after it was issued, through the bypass.
    run_rr(cpu_pkg::ALU_ADD, isa_pkg::F7_BASE, isa_pkg::F3_ADD_SUB, 5'd13, 5'd1, 5'd2);
    run_rr(cpu_pkg::ALU_SUB, isa_pkg::F7_ALT, isa_pkg::F3_ADD_SUB, 5'd14, 5'd5, 5'd1);
    run_rr(cpu_pkg::ALU_XOR, isa_pkg::F7_BASE, isa_pkg::F3_XOR, 5'd15, 5'd13, 5'd2);
    finish_test("op", err0);
  endtask

  task automatic mul_set(input logic [31:0] a, input logic [31:0] b);
    load(5'd1, a);
    load(5'd2, b);
    run_rr(cpu_pkg::ALU_MUL, isa_pkg::F7_MULDIV, isa_pkg::F3_MUL, 5'd3, 5'd1, 5'd2);
    run_rr(cpu_pkg::ALU_MULH, isa_pkg::F7_MULDIV, isa_pkg::F3_MULH, 5'd4, 5'd1, 5'd2);
    run_rr(cpu_pkg::ALU_MULHSU, isa_pkg::F7_MULDIV, isa_pkg::F3_MULHSU, 5'd5, 5'd1, 5'd2);
    run_rr(cpu_pkg::ALU_MULHU, isa_pkg::F7_MULDIV, isa_pkg::F3_MULHU, 5'd6, 5'd1, 5'd2);
  endtask

  task automatic test_mul();
    int err0;
    err0 = errors;
    mul_set(rand_word(32), rand_word(32));
    mul_set(rand_word(32) | 32'h8000_0000, rand_word(31));
    mul_set(32'h8000_0000, 32'hffff_ffff);
    mul_set(32'h8000_0000, 32'h8000_0000);
    mul_set(32'hffff_ffff, rand_word(32));
    mul_set(32'h0000_0000, rand_word(32) | 32'h8000_0000);
    finish_test("multiply", err0);
  endtask

  task automatic test_upper_link_store();
    int          err0;
    logic [19:0] imm20;
    logic [11:0] simm;
    err0  = errors;
    load(5'd1, rand_word(32));
    load(5'd2, rand_word(32));
    imm20 = 20'(rand_word(20));
    simm  = 12'(rand_word(12));
    issue(u_type(imm20, 5'd3, isa_pkg::OPC_LUI), 1'b1, 5'd3, {imm20, 12'b0}, 1'b0);
    issue(u_type(imm20, 5'd4, isa_pkg::OPC_AUIPC), 1'b1, 5'd4, pc + {imm20, 12'b0}, 1'b0);
    issue(j_type({20'(rand_word(20)), 1'b0}, 5'd5), 1'b1, 5'd5, pc + 32'd4, 1'b0);
    issue(i_type(12'(rand_word(12)), 5'd1, isa_pkg::F3_JALR, 5'd6, isa_pkg::OPC_JALR),
          1'b1, 5'd6, pc + 32'd4, 1'b0);
    issue(s_type(simm, 5'd2, 5'd1, isa_pkg::F3_SW), 1'b0, simm[4:0],
          regs_m[1] + sext12(simm), 1'b0); // result is the store address.
    finish_test("upper/jump", err0);
  endtask

  task automatic test_illegal_x0();
    int err0;
    err0 = errors;
    // division is not built, so DIV and REM decode as illegal.
    issue(r_type(isa_pkg::F7_MULDIV, 3'b100, 5'd3, 5'd1, 5'd2), 1'b0, 5'd3,
          regs_m[1] + regs_m[2], 1'b1);
    issue(r_type(isa_pkg::F7_MULDIV, 3'b110, 5'd4, 5'd1, 5'd2), 1'b0, 5'd4,
          regs_m[1] + regs_m[2], 1'b1);
    run_rr(cpu_pkg::ALU_ADD, isa_pkg::F7_BASE, isa_pkg::F3_ADD_SUB, 5'd8, 5'd3, 5'd0);
    run_rr(cpu_pkg::ALU_ADD, isa_pkg::F7_BASE, isa_pkg::F3_ADD_SUB, 5'd9, 5'd4, 5'd0);
    run_ri(cpu_pkg::ALU_ADD, isa_pkg::F3_ADD_SUB, 12'h005, 5'd0, 5'd1);
    idle(1);
    run_rr(cpu_pkg::ALU_OR, isa_pkg::F7_BASE, isa_pkg::F3_OR, 5'd10, 5'd0, 5'd0);
    finish_test("illegal/x0", err0);
  endtask

  // compare each writeback with the oldest instruction in flight.
  always @(negedge clk) begin
    if (!rst && wb_valid) begin
      if (exp_q.size() == 0) begin
        $display("Unexpected writeback at %0t ns with no instruction in flight", $time);
        errors++;
      end else begin
        got = exp_q.pop_front();
        if (due_q.pop_front() != $time) begin
          $display("Writeback at %0t ns did not come two cycles after its issue", $time);
          errors++;
        end
        check_value("wb_we_o", 32'(got[69]), 32'(wb_we));
        check_value("wb_illegal_o", 32'(got[70]), 32'(wb_illegal));
        check_value("wb_addr_o", 32'(got[68:64]), 32'(wb_addr));
        check_value("wb_data_o", got[31:0], wb_data);
        if (!got[69] && !got[70]) begin
          check_value("store_data_o", got[63:32], store_data);
        end
      end
    end else if (!rst && (due_q.size() != 0) && (due_q[0] <= $time)) begin
      $display("No writeback at %0t ns for an instruction that was issued", $time);
      errors++;
      got = exp_q.pop_front();
      due_q.delete(0);
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT_CYCLES) begin
      $display("Simulation timed out after %0d cycles", cycles);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    rst        = 1'b1;
    inst_valid = 1'b0;
    inst       = '0;
    inst_pc    = '0;
    for (int i = 0; i < 32; i++) begin
      regs_m[i] = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
    test_idle();
    test_op_imm();
    test_op();
    test_mul();
    test_upper_link_store();
    test_illegal_x0();
    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+logic
logic/cpu_pkg.sv
logic/isa_pkg.sv
logic/regfile.sv
logic/id.sv
logic/pipe_reg.sv
logic/ex.sv
logic/ex_core.sv
verif/tb_ex_core.sv

// File: Makefile
TOP      ?= tb_ex_core
FILELIST ?= all.f
SRCS     ?= logic/cpu_params.svh logic/cpu_pkg.sv logic/isa_pkg.sv logic/regfile.sv \
            logic/id.sv logic/pipe_reg.sv logic/ex.sv logic/ex_core.sv verif/tb_ex_core.sv
VFLAGS   ?= --binary --timing -Wno-fatal
OBJ_DIR  ?= obj_dir
SIM      := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	verilator $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf $(OBJ_DIR)
